//--- project.f
+incdir+.
io_pkg.sv
uart_link_if.sv
uart_transmitter.sv
uart_receiver.sv
uart.sv
perf_counters.sv
io_control.sv
io_subsystem.sv
tb_io_subsystem.sv

//--- tb_io_subsystem.sv
`timescale 1ns/10ps
`include "io_settings.svh"

module tb_io_subsystem;
	import io_pkg::*;

	logic       clk = 1'b0;
	logic       cpu_rst;
	logic       io_en;
	logic [3:0] wea;
	io_addr_t   adr;
	word_t      din_io;
	word_t      dout_io;
	logic       instr_stop;
	logic       uart_serial_in;
	logic       uart_serial_out;
	logic       loopback;
	logic       bit_line;
	integer     seed = 63;
	word_t      rd;
	word_t      first;
	byte_t      tx_byte;
	logic [9:0] line_bits;
	logic       stop_bit;
	int         tmo;
	int         cnt;
	int         k;
	int         m;

	io_subsystem dut (.*);

	assign uart_serial_in = loopback ? uart_serial_out : bit_line;

	always #4 clk = ~clk;

	// Start bit, then data LSB first, then the stop bit
	function automatic logic [9:0] frame_bits(input byte_t b);
		logic [9:0] f;
		f[0] = 1'b0;
		for (int i = 0; i < 8; i++) begin
			f[i + 1] = b[i];
		end
		f[9] = 1'b1;
		return f;
	endfunction

	function automatic word_t expected_status(input logic rx_pending, input logic tx_busy);
		word_t s;
		s = '0;
		s[1] = rx_pending;
		s[0] = !tx_busy;
		return s;
	endfunction

	task automatic check_value(input word_t actual, input word_t expected, input string what);
		if (actual !== expected) begin
			$display("Error at %0t ns: %s is 0x%0h, expected 0x%0h",
				$time, what, actual, expected);
			$display("Simulation FAILED");
			$fatal(1, "mismatch on %s", what);
		end
	endtask

	task automatic give_up(input string what);
		$display("Timed out waiting for %s", what);
		$display("Simulation FAILED");
		$fatal(1, "timeout");
	endtask

	// Returns just after the access edge
	task automatic bus_access(input io_addr_t a, input logic [3:0] w, input word_t d);
		@(posedge clk);
		io_en <= 1'b1;
		wea <= w;
		adr <= a;
		din_io <= d;
		@(posedge clk);
		io_en <= 1'b0;
		wea <= 4'd0;
	endtask

	task automatic bus_write(input io_addr_t a, input word_t d);
		logic [3:0] mask;
		mask = 4'({$random(seed)} % 15 + 1);
		bus_access(a, mask, d);
	endtask

	// dout_io is stable between the access edge and the next one
	task automatic capture_read(output word_t data);
		@(negedge clk);
		data = dout_io;
	endtask

	task automatic bus_read(input io_addr_t a, output word_t data);
		bus_access(a, 4'd0, word_t'($random(seed)));
		capture_read(data);
	endtask

	task automatic poll_status(input int idx, input string what, output word_t s);
		int tries;
		tries = 0;
		s = '0;
		while (!s[idx]) begin
			if (tries == 300) give_up(what);
			tries++;
			bus_read(io_addr_t'(`IO_ADDR_UART_CTRL), s);
		end
	endtask

	task automatic send_frame(input byte_t b);
		logic [9:0] f;
		f = frame_bits(b);
		for (int i = 0; i < 10; i++) begin
			@(posedge clk);
			bit_line <= f[i];
			repeat (7) @(posedge clk);
		end
	endtask

	initial begin
		cpu_rst = 1'b1;
		io_en = 1'b0;
		wea = 4'd0;
		adr = '0;
		din_io = '0;
		instr_stop = 1'b0;
		loopback = 1'b0;
		bit_line = 1'b1;
		repeat (8) @(posedge clk);
		cpu_rst <= 1'b0;

		bus_read(io_addr_t'(`IO_ADDR_UART_CTRL), rd);
		check_value(rd, expected_status(1'b0, 1'b0), "status after reset");
		@(negedge clk);
		check_value(dout_io, '0, "dout_io between reads");
		bus_read(io_addr_t'(3), rd);
		check_value(rd, '0, "unmapped address 3");
		bus_read(io_addr_t'(7), rd);
		check_value(rd, '0, "unmapped address 7");
		bus_write(io_addr_t'(`IO_ADDR_UART_CTRL), word_t'($random(seed)));
		capture_read(rd);
		check_value(rd, '0, "dout_io after a write");
		repeat (16) begin
			@(negedge clk);
			check_value(word_t'(uart_serial_out), word_t'(1), "idle serial line");
		end

		// Transmit frame is sampled mid-bit from the start edge
		tx_byte = byte_t'($random(seed));
		first = word_t'($random(seed));
		first[7:0] = tx_byte;
		bus_write(io_addr_t'(`IO_ADDR_UART_TX), first);
		tmo = 0;
		while (uart_serial_out) begin
			if (tmo == 20) give_up("the start bit");
			tmo++;
			@(negedge clk);
		end
		repeat (3) @(negedge clk);
		for (int i = 0; i < 10; i++) begin
			if (i > 0) repeat (8) @(negedge clk);
			line_bits[i] = uart_serial_out;
		end
		check_value(word_t'(line_bits), word_t'(frame_bits(tx_byte)), "transmit frame");
		poll_status(0, "tx_ready after the frame", rd);

		tx_byte = byte_t'($random(seed));
		send_frame(tx_byte);
		poll_status(1, "rx_valid", rd);
		check_value(rd, expected_status(1'b1, 1'b0), "status with a byte pending");
		bus_read(io_addr_t'(`IO_ADDR_UART_RX), rd);
		check_value(rd, word_t'(tx_byte), "received byte");
		bus_read(io_addr_t'(`IO_ADDR_UART_CTRL), rd);
		check_value(rd, expected_status(1'b0, 1'b0), "status after the byte was taken");

		@(posedge clk);
		loopback <= 1'b1;
		for (int n = 0; n < 8; n++) begin
			poll_status(0, "tx_ready in loopback", rd);
			tx_byte = byte_t'($random(seed));
			bus_write(io_addr_t'(`IO_ADDR_UART_TX), word_t'(tx_byte));
			poll_status(1, "a looped-back byte", rd);
			bus_read(io_addr_t'(`IO_ADDR_UART_RX), rd);
			check_value(rd, word_t'(tx_byte), "looped-back byte");
		end

		// Read access edges are exactly m cycles apart
		k = {$random(seed)} % 16;
		m = 2 + {$random(seed)} % 40;
		bus_write(io_addr_t'(`IO_ADDR_CNT_RST), word_t'($random(seed)));
		repeat (k) @(posedge clk);
		bus_read(io_addr_t'(`IO_ADDR_CYCLE_CNT), first);
		check_value(first, word_t'(k), "cycle count after clear");
		repeat (m - 2) @(posedge clk);
		bus_read(io_addr_t'(`IO_ADDR_CYCLE_CNT), rd);
		check_value(rd - first, word_t'(m), "cycle count difference");

		bus_write(io_addr_t'(`IO_ADDR_CNT_RST), word_t'($random(seed)));
		// This edge clears, so instr_stop counts from the next one
		@(posedge clk);
		stop_bit = 1'($random(seed));
		instr_stop <= stop_bit;
		cnt = 0;
		repeat (20 + {$random(seed)} % 30) begin
			@(posedge clk);
			if (!stop_bit) cnt++;
			stop_bit = 1'($random(seed));
			instr_stop <= stop_bit;
		end
		// Held value is also seen on the edge before the access edge
		if (!stop_bit) cnt++;
		bus_read(io_addr_t'(`IO_ADDR_INSTR_CNT), rd);
		check_value(rd, word_t'(cnt), "instruction count");

		$display("Simulation PASSED");
		$finish;
	end

endmodule

//--- io_subsystem.sv
`timescale 1ns/10ps
`include "io_settings.svh"

module io_subsystem #(
	parameter int CPU_CLOCK_FREQ = `IO_CLOCK_FREQ,
	parameter int BAUD_RATE = `IO_BAUD_RATE
) (
	input  logic             clk,
	input  logic             cpu_rst,
	input  logic             io_en,
	input  logic [3:0]       wea,
	input  io_pkg::io_addr_t adr,
	input  io_pkg::word_t    din_io,
	output io_pkg::word_t    dout_io,
	input  logic             instr_stop,
	input  logic             uart_serial_in,
	output logic             uart_serial_out
);
	import io_pkg::*;

	word_t cycle_cnt;
	word_t instr_cnt;
	logic  counter_clr;

	uart_link_if link ();

	io_control u_ctrl (
		.clk        (clk),
		.cpu_rst    (cpu_rst),
		.io_en      (io_en),
		.wea        (wea),
		.adr        (adr),
		.din_io     (din_io),
		.dout_io    (dout_io),
		.cycle_cnt  (cycle_cnt),
		.instr_cnt  (instr_cnt),
		.counter_clr(counter_clr),
		.link       (link.ctrl)
	);

	uart #(
		.CLOCK_FREQ(CPU_CLOCK_FREQ),
		.BAUD_RATE (BAUD_RATE)
	) u_uart (
		.clk       (clk),
		.cpu_rst   (cpu_rst),
		.link      (link.uart),
		.serial_in (uart_serial_in),
		.serial_out(uart_serial_out)
	);

	perf_counters u_counters (
		.clk        (clk),
		.cpu_rst    (cpu_rst),
		.counter_clr(counter_clr),
		.instr_stop (instr_stop),
		.cycle_cnt  (cycle_cnt),
		.instr_cnt  (instr_cnt)
	);

endmodule

//--- io_control.sv
`timescale 1ns/10ps
`include "io_settings.svh"

module io_control (
	input  logic             clk,
	input  logic             cpu_rst,
	input  logic             io_en,
	input  logic [3:0]       wea,
	input  io_pkg::io_addr_t adr,
	input  io_pkg::word_t    din_io,
	output io_pkg::word_t    dout_io,
	input  io_pkg::word_t    cycle_cnt,
	input  io_pkg::word_t    instr_cnt,
	output logic             counter_clr,
	uart_link_if.ctrl        link
);
	import io_pkg::*;

	uart_status_t status;
	word_t        rd_word;
	logic         is_read;
	logic         is_write;

	assign status.rx_valid = link.rx_valid;
	assign status.tx_ready = link.tx_ready;

	// Any nonzero byte mask counts as a full write
	assign is_write = io_en && (wea != 4'd0);
	assign is_read = io_en && (wea == 4'd0);

	always_comb begin
		case (adr)
			io_addr_t'(`IO_ADDR_UART_CTRL):
				rd_word = {{(`XLEN - $bits(uart_status_t)){1'b0}}, status};
			io_addr_t'(`IO_ADDR_UART_RX):
				rd_word = {{(`XLEN - 8){1'b0}}, link.rx_data};
			io_addr_t'(`IO_ADDR_CYCLE_CNT):
				rd_word = cycle_cnt;
			io_addr_t'(`IO_ADDR_INSTR_CNT):
				rd_word = instr_cnt;
			default:
				rd_word = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (cpu_rst) begin
			dout_io <= '0;
			link.tx_valid <= 1'b0;
			link.rx_ready <= 1'b0;
			counter_clr <= 1'b0;
		end else begin
			// Read data is valid for one cycle after a read access
			dout_io <= is_read ? rd_word : '0;
			// Byte is dropped if the transmitter is busy
			link.tx_valid <= is_write && (adr == io_addr_t'(`IO_ADDR_UART_TX)) &&
				link.tx_ready;
			link.rx_ready <= is_read && (adr == io_addr_t'(`IO_ADDR_UART_RX));
			counter_clr <= is_write && (adr == io_addr_t'(`IO_ADDR_CNT_RST));
		end
	end

	always_ff @(posedge clk) begin
		if (is_write && (adr == io_addr_t'(`IO_ADDR_UART_TX))) begin
			link.tx_data <= din_io[7:0];
		end
	end

endmodule

//--- perf_counters.sv
`timescale 1ns/10ps

module perf_counters (
	input  logic          clk,
	input  logic          cpu_rst,
	input  logic          counter_clr,
	input  logic          instr_stop,
	output io_pkg::word_t cycle_cnt,
	output io_pkg::word_t instr_cnt
);
	import io_pkg::*;

	// Counts every clock
	always_ff @(posedge clk) begin
		if (cpu_rst || counter_clr) begin
			cycle_cnt <= '0;
		end else begin
			cycle_cnt <= cycle_cnt + word_t'(1);
		end
	end

	// Counts only while the pipeline is not stalled
	always_ff @(posedge clk) begin
		if (cpu_rst || counter_clr) begin
			instr_cnt <= '0;
		end else if (!instr_stop) begin
			instr_cnt <= instr_cnt + word_t'(1);
		end
	end

endmodule

//--- uart.sv
`timescale 1ns/10ps
`include "io_settings.svh"

module uart #(
	parameter int CLOCK_FREQ = `IO_CLOCK_FREQ,
	parameter int BAUD_RATE = `IO_BAUD_RATE
) (
	input  logic             clk,
	input  logic             cpu_rst,
	uart_link_if.uart        link,
	input  logic             serial_in,
	output logic             serial_out
);
	localparam int CLOCKS_PER_BIT = CLOCK_FREQ / BAUD_RATE;

	uart_transmitter #(
		.CLOCKS_PER_BIT(CLOCKS_PER_BIT)
	) u_tx (
		.clk       (clk),
		.cpu_rst   (cpu_rst),
		.data      (link.tx_data),
		.data_valid(link.tx_valid),
		.data_ready(link.tx_ready),
		.serial_out(serial_out)
	);

	uart_receiver #(
		.CLOCKS_PER_BIT(CLOCKS_PER_BIT)
	) u_rx (
		.clk       (clk),
		.cpu_rst   (cpu_rst),
		.serial_in (serial_in),
		.data      (link.rx_data),
		.data_valid(link.rx_valid),
		.data_ready(link.rx_ready)
	);

endmodule

//--- uart_receiver.sv
`timescale 1ns/10ps

module uart_receiver #(
	parameter int CLOCKS_PER_BIT = 8
) (
	input  logic          clk,
	input  logic          cpu_rst,
	input  logic          serial_in,
	output io_pkg::byte_t data,
	output logic          data_valid,
	input  logic          data_ready
);
	import io_pkg::*;

	localparam int CNT_W = (CLOCKS_PER_BIT > 2) ? $clog2(CLOCKS_PER_BIT) : 1;
	localparam int HALF_BIT = CLOCKS_PER_BIT / 2;

	logic [1:0]       rx_sync;
	logic             rx_line;
	logic             rx_prev;
	logic             busy;
	logic [3:0]       bit_idx;
	logic [CNT_W-1:0] clk_cnt;
	logic             sample_tick;
	byte_t            shift_reg;

	assign rx_line = rx_sync[1];
	assign sample_tick = busy && (clk_cnt == '0);

	// bit_idx 0 is the start bit, 1..8 data, 9 stop, 10 the delay before valid
	always_ff @(posedge clk) begin
		if (cpu_rst) begin
			rx_sync <= 2'b11;
			rx_prev <= 1'b1;
			busy <= 1'b0;
			bit_idx <= '0;
			clk_cnt <= '0;
			data_valid <= 1'b0;
		end else begin
			rx_sync <= {rx_sync[0], serial_in};
			rx_prev <= rx_line;
			if (data_ready) begin
				data_valid <= 1'b0;
			end
			if (!busy) begin
				if (rx_prev && !rx_line) begin
					busy <= 1'b1;
					bit_idx <= '0;
					clk_cnt <= CNT_W'(HALF_BIT - 1);
				end
			end else if (!sample_tick) begin
				clk_cnt <= clk_cnt - 1'b1;
			end else begin
				clk_cnt <= CNT_W'(CLOCKS_PER_BIT - 1);
				bit_idx <= bit_idx + 4'd1;
				case (bit_idx)
					4'd0: begin
						// Line went back high, so this was a glitch
						if (rx_line) begin
							busy <= 1'b0;
						end
					end
					4'd9: begin
						if (!rx_line) begin
							busy <= 1'b0;
						end else begin
							clk_cnt <= CNT_W'(HALF_BIT - 1);
						end
					end
					4'd10: begin
						busy <= 1'b0;
						data_valid <= 1'b1;
					end
					default: begin
					end
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (sample_tick && (bit_idx >= 4'd1) && (bit_idx <= 4'd8)) begin
			shift_reg <= {rx_line, shift_reg[7:1]};
		end
		// An unread byte is simply overwritten
		if (sample_tick && (bit_idx == 4'd10)) begin
			data <= shift_reg;
		end
	end

endmodule

//--- uart_transmitter.sv
`timescale 1ns/10ps

module uart_transmitter #(
	parameter int CLOCKS_PER_BIT = 8
) (
	input  logic          clk,
	input  logic          cpu_rst,
	input  io_pkg::byte_t data,
	input  logic          data_valid,
	output logic          data_ready,
	output logic          serial_out
);
	localparam int CNT_W = (CLOCKS_PER_BIT > 2) ? $clog2(CLOCKS_PER_BIT) : 1;

	logic [9:0]       frame;
	logic [3:0]       bits_left;
	logic [CNT_W-1:0] clk_cnt;
	logic             bit_done;

	assign bit_done = (clk_cnt == CNT_W'(CLOCKS_PER_BIT - 1));

	// LSB of the frame register is the line
	assign serial_out = frame[0];

	always_ff @(posedge clk) begin
		if (cpu_rst) begin
			frame <= '1;
			bits_left <= '0;
			clk_cnt <= '0;
			data_ready <= 1'b1;
		end else if (data_valid && data_ready) begin
			// Stop bit, data LSB first, start bit
			frame <= {1'b1, data, 1'b0};
			bits_left <= 4'd10;
			clk_cnt <= '0;
			data_ready <= 1'b0;
		end else if (!data_ready) begin
			if (bit_done) begin
				clk_cnt <= '0;
				frame <= {1'b1, frame[9:1]};
				bits_left <= bits_left - 4'd1;
				if (bits_left == 4'd1) begin
					data_ready <= 1'b1;
				end
			end else begin
				clk_cnt <= clk_cnt + 1'b1;
			end
		end
	end

endmodule

//--- uart_link_if.sv
`timescale 1ns/10ps

interface uart_link_if;
	import io_pkg::*;

	// Byte going out on the serial line
	byte_t tx_data;
	logic  tx_valid;
	logic  tx_ready;

	// Byte taken from the serial line
	byte_t rx_data;
	logic  rx_valid;
	logic  rx_ready;

	modport ctrl (
		output tx_data, tx_valid, rx_ready,
		input  tx_ready, rx_data, rx_valid
	);

	modport uart (
		input  tx_data, tx_valid, rx_ready,
		output tx_ready, rx_data, rx_valid
	);

endinterface

//--- io_pkg.sv
`include "io_settings.svh"

package io_pkg;

	// CPU data word
	typedef logic [`XLEN-1:0] word_t;

	// Word address inside the I/O window
	typedef logic [`IO_MAP_WIDTH-1:0] io_addr_t;

	// UART payload
	typedef logic [7:0] byte_t;

	// UART status register is zero-extended on read
	typedef struct packed {
		logic rx_valid;
		logic tx_ready;
	} uart_status_t;

endpackage

//--- io_settings.svh
`ifndef IO_SETTINGS_SVH
`define IO_SETTINGS_SVH

// Datapath and I/O window widths
`define XLEN 32
`define IO_MAP_WIDTH 5

// Word addresses inside the I/O window
`define IO_ADDR_UART_CTRL 0
`define IO_ADDR_UART_RX 1
`define IO_ADDR_UART_TX 2
`define IO_ADDR_CYCLE_CNT 4
`define IO_ADDR_INSTR_CNT 5
`define IO_ADDR_CNT_RST 6

// Defaults give 8 clocks per bit
`define IO_CLOCK_FREQ 1_000_000
`define IO_BAUD_RATE 125_000

`endif
